// ==== logic/controller.sv ====
module controller (
  input  logic                       clk,
  input  logic                       arstN,
  input  logic [ctrlPkg::instrW-1:0] InstrD,
  input  logic                       IllegalIeuInstrD,
  input  logic                       StallD,
  input  logic                       FlushD,
  input  logic                       StallE,
  input  logic                       FlushE,
  input  logic                       StallM,
  input  logic                       FlushM,
  input  logic                       StallW,
  input  logic                       FlushW,
  input  logic [1:0]                 FlagsE,        // {equal, less-than}
  output ctrlPkg::decodeOutT         decodeOut,
  output logic                       InstrValidD,
  output ctrlPkg::execOutT           execOut,
  output ctrlPkg::memCtrlT           memOut,
  output ctrlPkg::wbCtrlT            wbOut,
  output ctrlPkg::hazardOutT         hazardOut,
  output logic                       CsrWriteFenceM
);

  ctrlPkg::execCtrlT           decodedCtrl;         // Decoder to Execute register
  logic [ctrlPkg::regAdrW-1:0] rdD;
  logic [ctrlPkg::regAdrW-1:0] rs1E;                // For forwarding A

  //////////////////////////////
  // Decode
  instrDecode instrDecodeInst (
    .InstrD, .IllegalIeuInstrD, .decodeOut, .decodedCtrl, .rdD
  );

  //////////////////////////////
  // Pipeline stages
  executeStage executeStageInst (
    .clk, .arstN, .StallD, .FlushD, .StallE, .FlushE,
    .decodedCtrl,
    .rs1D(decodeOut.rs1),
    .rs2D(decodeOut.rs2),
    .rdD,
    .FlagsE, .InstrValidD, .execOut, .rs1E
  );

  memWbStage memWbStageInst (
    .clk, .arstN, .StallM, .FlushM, .StallW, .FlushW,
    .execOut, .memOut, .wbOut, .CsrWriteFenceM
  );

  //////////////////////////////
  // Forwarding and stalls
  hazardUnit hazardUnitInst (
    .decodeOut, .execOut, .rs1E, .memOut, .wbOut, .hazardOut
  );

endmodule

// ==== logic/ctrlPkg.sv ====
package ctrlPkg;

  //////////////////////////////
  // Widths fixed by the ISA
  localparam int regAdrW = 5;                   // Register address
  localparam int instrW  = 32;                  // Instruction word

  //////////////////////////////
  // Encodings
  typedef enum logic [6:0] {
    opcLoad    = 7'b0000011,
    opcMiscMem = 7'b0001111,                    // Fence only
    opcOpImm   = 7'b0010011,
    opcAuipc   = 7'b0010111,
    opcStore   = 7'b0100011,
    opcOp      = 7'b0110011,                    // R-type and mul/div
    opcLui     = 7'b0110111,
    opcBranch  = 7'b1100011,
    opcJalr    = 7'b1100111,
    opcJal     = 7'b1101111,
    opcSystem  = 7'b1110011                     // CSR and privileged
  } opcodeE;

  typedef enum logic [2:0] {
    immI = 3'b000, immS = 3'b001, immB = 3'b010, immJ = 3'b011, immU = 3'b100
  } immSrcE;

  typedef enum logic [2:0] {
    resAlu = 3'b000, resMem = 3'b001, resCsr = 3'b010, resMdu = 3'b011
  } resultSrcE;

  // Same order as funct3 so ALU ops pass straight through
  typedef enum logic [2:0] {
    aluAdd, aluSll, aluSlt, aluSltu, aluXor, aluShr, aluOr, aluAnd
  } aluSelE;

  typedef enum logic [1:0] {
    fwdNone = 2'b00, fwdWb = 2'b01, fwdMem = 2'b10
  } forwardE;

  //////////////////////////////
  // Stage control words
  typedef struct packed {
    immSrcE              immSrc;
    logic                illegal;
    logic                jump;
    logic                branch;
    logic [regAdrW-1:0]  rs1;
    logic [regAdrW-1:0]  rs2;
    logic [1:0]          memRw;                 // {read, write}
    logic                csrRead;
  } decodeOutT;

  typedef struct packed {
    logic                regWrite;
    resultSrcE           resultSrc;
    logic [1:0]          memRw;                 // {read, write}
    logic                jump;
    logic                branch;
    logic                aluSrcA;               // PC instead of rs1
    logic                aluSrcB;               // Immediate instead of rs2
    logic                aluResultSrc;          // Pass immediate or link value
    logic                csrRead;
    logic                csrWrite;
    logic                privileged;            // ecall ebreak mret
    logic [2:0]          funct3;
    logic                subArith;              // sub sra slt sltu
    logic                mdu;
    aluSelE              aluSel;
    logic                valid;
  } execCtrlT;

  typedef struct packed {
    execCtrlT            ctrl;
    logic                branchSigned;
    logic                pcSrc;                 // Redirect fetch
    logic                intDiv;
    logic [regAdrW-1:0]  rs2;
    logic [regAdrW-1:0]  rd;
  } execOutT;

  typedef struct packed {
    logic                regWrite;
    resultSrcE           resultSrc;
    logic [1:0]          memRw;
    logic                csrRead;
    logic                csrWrite;
    logic                privileged;
    logic [2:0]          funct3;
    logic                intDiv;
    logic                valid;
    logic [regAdrW-1:0]  rd;
  } memCtrlT;

  typedef struct packed {
    logic                regWrite;
    resultSrcE           resultSrc;
    logic                intDiv;
    logic [regAdrW-1:0]  rd;
  } wbCtrlT;

  typedef struct packed {
    forwardE             forwardA;
    forwardE             forwardB;
    logic                loadStall;
    logic                storeStall;
    logic                structuralStall;
  } hazardOutT;

endpackage

// ==== logic/executeStage.sv ====
module executeStage (
  input  logic                        clk,
  input  logic                        arstN,
  input  logic                        StallD,
  input  logic                        FlushD,
  input  logic                        StallE,
  input  logic                        FlushE,
  input  ctrlPkg::execCtrlT           decodedCtrl,  // Word from the decoder
  input  logic [ctrlPkg::regAdrW-1:0] rs1D,
  input  logic [ctrlPkg::regAdrW-1:0] rs2D,
  input  logic [ctrlPkg::regAdrW-1:0] rdD,
  input  logic [1:0]                  FlagsE,       // {equal, less-than}
  output logic                        InstrValidD,
  output ctrlPkg::execOutT            execOut,
  output logic [ctrlPkg::regAdrW-1:0] rs1E          // Only the hazard unit needs it
);

  ctrlPkg::execCtrlT           ctrlNextE, ctrlE;
  logic [ctrlPkg::regAdrW-1:0] rs2E, rdE;
  logic                        eqE, ltE;
  logic                        branchFlagE, branchTakenE;

  // Decode holds a real instruction once it has been loaded and not flushed
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)
      InstrValidD <= 1'b0;
    else if (FlushD | !StallD)
      InstrValidD <= !FlushD;                         // Flush wins over load
  end

  always_comb begin
    ctrlNextE       = decodedCtrl;
    ctrlNextE.valid = InstrValidD;                    // Carry Decode validity along
  end

  //////////////////////////////
  // Execute register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlE <= '0;
      rs1E  <= '0;
      rs2E  <= '0;
      rdE   <= '0;
    end else if (FlushE | !StallE) begin            // Stall holds everything
      ctrlE <= FlushE ? '0 : ctrlNextE;
      rs1E  <= FlushE ? '0 : rs1D;
      rs2E  <= FlushE ? '0 : rs2D;
      rdE   <= FlushE ? '0 : rdD;
    end
  end

  //////////////////////////////
  // Branch resolution
  assign {eqE, ltE}   = FlagsE;
  assign branchFlagE  = ctrlE.funct3[2] ? ltE : eqE;       // blt bge bltu bgeu look at lt
  assign branchTakenE = branchFlagE ^ ctrlE.funct3[0];     // bne bge bgeu invert

  assign execOut = '{ctrl:         ctrlE,
                     branchSigned: ctrlE.branch & (ctrlE.funct3[2:1] != 2'b11),
                     pcSrc:        ctrlE.jump | (ctrlE.branch & branchTakenE),
                     intDiv:       ctrlE.mdu & ctrlE.funct3[2],  // div divu rem remu
                     rs2:          rs2E,
                     rd:           rdE};

endmodule

// ==== logic/hazardUnit.sv ====
module hazardUnit (
  input  ctrlPkg::decodeOutT          decodeOut,
  input  ctrlPkg::execOutT            execOut,
  input  logic [ctrlPkg::regAdrW-1:0] rs1E,
  input  ctrlPkg::memCtrlT            memOut,
  input  ctrlPkg::wbCtrlT             wbOut,
  output ctrlPkg::hazardOutT          hazardOut
);

  logic matchDE;                                  // Decode source hits Execute rd
  logic loadStallD, storeStallD, csrRdStallD, mduStallD;

  // Memory result is younger so it takes priority over Writeback
  function automatic ctrlPkg::forwardE fwdSel(input logic [ctrlPkg::regAdrW-1:0] src,
                                              input ctrlPkg::memCtrlT            mem,
                                              input ctrlPkg::wbCtrlT             wb);
    fwdSel = ctrlPkg::fwdNone;
    if (src != '0) begin                          // x0 is never forwarded
      if (src == mem.rd && mem.regWrite)
        fwdSel = ctrlPkg::fwdMem;
      else if (src == wb.rd && wb.regWrite)
        fwdSel = ctrlPkg::fwdWb;
    end
  endfunction

  //////////////////////////////
  // Structural stalls
  assign matchDE = ((decodeOut.rs1 == execOut.rd) | (decodeOut.rs2 == execOut.rd))
                   & (execOut.rd != '0);
  assign loadStallD  = execOut.ctrl.memRw[1] & matchDE;          // Load data not ready yet
  assign storeStallD = decodeOut.memRw[1] & execOut.ctrl.memRw[0]; // Load right behind a store
  assign csrRdStallD = execOut.ctrl.csrRead & matchDE;
  assign mduStallD   = execOut.ctrl.mdu & matchDE;                // Multicycle result

  assign hazardOut = '{forwardA:        fwdSel(rs1E, memOut, wbOut),
                       forwardB:        fwdSel(execOut.rs2, memOut, wbOut),
                       loadStall:       loadStallD,
                       storeStall:      storeStallD,
                       structuralStall: loadStallD | storeStallD | csrRdStallD | mduStallD};

endmodule

// ==== logic/instrDecode.sv ====
module instrDecode (
  input  logic [ctrlPkg::instrW-1:0]  InstrD,            // Instruction in Decode
  input  logic                        IllegalIeuInstrD,  // Flagged illegal upstream
  output ctrlPkg::decodeOutT          decodeOut,         // Decode-stage results
  output ctrlPkg::execCtrlT           decodedCtrl,       // Control word for Execute
  output logic [ctrlPkg::regAdrW-1:0] rdD                // Destination register
);

  ctrlPkg::opcodeE             opD;
  logic [2:0]                  funct3D;
  logic [6:0]                  funct7D;
  logic [ctrlPkg::regAdrW-1:0] rs1D, rs2D;
  logic                        funct7ZeroD, funct7b5D;
  logic                        iFunctD, rFunctD, mFunctD, lFunctD, sFunctD;
  logic                        bFunctD, jrFunctD, fenceFunctD, pFunctD, csrFunctD;
  logic                        subD, sraD, sltD, sltuD;
  logic                        aluOpD;                   // Op uses funct3 for the ALU
  logic                        illegalD;
  ctrlPkg::immSrcE             immSrcD;
  ctrlPkg::execCtrlT           ctrlD;

  // Fields
  assign opD     = ctrlPkg::opcodeE'(InstrD[6:0]);
  assign funct3D = InstrD[14:12];
  assign funct7D = InstrD[31:25];
  assign rs1D    = InstrD[19:15];
  assign rs2D    = InstrD[24:20];
  assign rdD     = InstrD[11:7];

  //////////////////////////////
  // Exact funct checks per class
  assign funct7ZeroD = (funct7D == 7'b0000000);
  assign funct7b5D   = (funct7D == 7'b0100000);  // sub or sra
  assign iFunctD     = (funct3D == 3'b001) ? funct7ZeroD :
                       (funct3D == 3'b101) ? (funct7ZeroD | funct7b5D) : 1'b1;
  assign rFunctD     = funct7ZeroD | (funct7b5D & (funct3D == 3'b000 | funct3D == 3'b101));
  assign mFunctD     = (funct7D == 7'b0000001);
  assign lFunctD     = (funct3D != 3'b011) & (funct3D[2:1] != 2'b11); // lb lh lw lbu lhu
  assign sFunctD     = ~funct3D[2] & (funct3D[1:0] != 2'b11);         // sb sh sw
  assign bFunctD     = (funct3D[2:1] != 2'b01);
  assign jrFunctD    = (funct3D == 3'b000);
  assign fenceFunctD = (funct3D == 3'b000);
  assign pFunctD     = (funct3D == 3'b000) & (rdD == '0);
  assign csrFunctD   = (funct3D[1:0] != 2'b00);

  // ALU op qualifiers
  assign sltD  = (funct3D == 3'b010);
  assign sltuD = (funct3D == 3'b011);
  assign subD  = (funct3D == 3'b000) & funct7D[5] & InstrD[5]; // Bit 5 splits sub from addi
  assign sraD  = (funct3D == 3'b101) & funct7D[5];

  //////////////////////////////
  // Main decoder
  always_comb begin
    ctrlD    = '0;
    immSrcD  = ctrlPkg::immI;
    aluOpD   = 1'b0;
    illegalD = 1'b1;                                      // Cleared by a legal match
    case (opD)
      ctrlPkg::opcLoad: if (lFunctD) begin
        illegalD        = 1'b0;
        ctrlD.regWrite  = 1'b1;
        ctrlD.aluSrcB   = 1'b1;                           // Base plus offset
        ctrlD.memRw     = 2'b10;
        ctrlD.resultSrc = ctrlPkg::resMem;
      end
      ctrlPkg::opcMiscMem: if (fenceFunctD) begin
        illegalD = 1'b0;                                  // Fence is a no-op here
      end
      ctrlPkg::opcOpImm: if (iFunctD) begin
        illegalD       = 1'b0;
        ctrlD.regWrite = 1'b1;
        ctrlD.aluSrcB  = 1'b1;
        aluOpD         = 1'b1;
      end
      ctrlPkg::opcAuipc: begin
        illegalD       = 1'b0;
        immSrcD        = ctrlPkg::immU;
        ctrlD.regWrite = 1'b1;
        ctrlD.aluSrcA  = 1'b1;                            // PC plus upper immediate
        ctrlD.aluSrcB  = 1'b1;
      end
      ctrlPkg::opcStore: if (sFunctD) begin
        illegalD      = 1'b0;
        immSrcD       = ctrlPkg::immS;
        ctrlD.aluSrcB = 1'b1;
        ctrlD.memRw   = 2'b01;
      end
      ctrlPkg::opcOp: if (rFunctD) begin
        illegalD       = 1'b0;
        ctrlD.regWrite = 1'b1;
        aluOpD         = 1'b1;
      end else if (mFunctD) begin
        illegalD        = 1'b0;
        ctrlD.regWrite  = 1'b1;
        ctrlD.resultSrc = ctrlPkg::resMdu;
        ctrlD.mdu       = 1'b1;
      end
      ctrlPkg::opcLui: begin
        illegalD           = 1'b0;
        immSrcD            = ctrlPkg::immU;
        ctrlD.regWrite     = 1'b1;
        ctrlD.aluSrcB      = 1'b1;
        ctrlD.aluResultSrc = 1'b1;                        // Immediate goes straight out
      end
      ctrlPkg::opcBranch: if (bFunctD) begin
        illegalD      = 1'b0;
        immSrcD       = ctrlPkg::immB;
        ctrlD.aluSrcA = 1'b1;                             // Target is PC plus offset
        ctrlD.aluSrcB = 1'b1;
        ctrlD.branch  = 1'b1;
      end
      ctrlPkg::opcJalr: if (jrFunctD) begin
        illegalD           = 1'b0;
        ctrlD.regWrite     = 1'b1;
        ctrlD.aluSrcB      = 1'b1;
        ctrlD.jump         = 1'b1;
        ctrlD.aluResultSrc = 1'b1;                        // Link address
      end
      ctrlPkg::opcJal: begin
        illegalD           = 1'b0;
        immSrcD            = ctrlPkg::immJ;
        ctrlD.regWrite     = 1'b1;
        ctrlD.aluSrcA      = 1'b1;
        ctrlD.aluSrcB      = 1'b1;
        ctrlD.jump         = 1'b1;
        ctrlD.aluResultSrc = 1'b1;
      end
      ctrlPkg::opcSystem: if (pFunctD) begin
        illegalD         = 1'b0;
        ctrlD.privileged = 1'b1;                          // ecall ebreak mret
      end else if (csrFunctD) begin
        illegalD        = 1'b0;
        ctrlD.regWrite  = 1'b1;
        ctrlD.csrRead   = 1'b1;
        ctrlD.resultSrc = ctrlPkg::resCsr;
      end
      default: illegalD = 1'b1;                           // Opcode outside RV32IM and Zicsr
    endcase

    ctrlD.funct3   = funct3D;
    ctrlD.subArith = aluOpD & (subD | sraD | sltD | sltuD);
    ctrlD.aluSel   = aluOpD ? ctrlPkg::aluSelE'(funct3D) : ctrlPkg::aluAdd;
    // Set or clear with x0 or a zero uimm only reads the CSR
    ctrlD.csrWrite = ctrlD.csrRead & ~(funct3D[1] & (rs1D == '0));

    if (IllegalIeuInstrD) begin                           // Squash the whole word
      ctrlD   = '0;
      immSrcD = ctrlPkg::immI;
    end
  end

  assign decodedCtrl = ctrlD;                             // valid is set by the Execute register
  assign decodeOut   = '{immSrc: immSrcD, illegal: illegalD, jump: ctrlD.jump,
                         branch: ctrlD.branch, rs1: rs1D, rs2: rs2D,
                         memRw: ctrlD.memRw, csrRead: ctrlD.csrRead};

endmodule

// ==== logic/memWbStage.sv ====
module memWbStage (
  input  logic              clk,
  input  logic              arstN,
  input  logic              StallM,
  input  logic              FlushM,
  input  logic              StallW,
  input  logic              FlushW,
  input  ctrlPkg::execOutT  execOut,
  output ctrlPkg::memCtrlT  memOut,
  output ctrlPkg::wbCtrlT   wbOut,
  output logic              CsrWriteFenceM       // Younger stages must refetch
);

  ctrlPkg::memCtrlT memNextM;
  ctrlPkg::wbCtrlT  wbNextW;

  // Keep only what Memory still needs
  assign memNextM = '{regWrite:   execOut.ctrl.regWrite,
                      resultSrc:  execOut.ctrl.resultSrc,
                      memRw:      execOut.ctrl.memRw,
                      csrRead:    execOut.ctrl.csrRead,
                      csrWrite:   execOut.ctrl.csrWrite,
                      privileged: execOut.ctrl.privileged,
                      funct3:     execOut.ctrl.funct3,
                      intDiv:     execOut.intDiv,
                      valid:      execOut.ctrl.valid,
                      rd:         execOut.rd};

  assign wbNextW = '{regWrite:  memOut.regWrite,
                     resultSrc: memOut.resultSrc,
                     intDiv:    memOut.intDiv,
                     rd:        memOut.rd};

  //////////////////////////////
  // Memory and Writeback registers
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)
      memOut <= '0;
    else if (FlushM | !StallM)
      memOut <= FlushM ? '0 : memNextM;          // Flush zeroes, stall holds
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)
      wbOut <= '0;
    else if (FlushW | !StallW)
      wbOut <= FlushW ? '0 : wbNextW;
  end

  assign CsrWriteFenceM = memOut.csrWrite;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbController -f verilog.f -o simController
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/simController)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

// ==== sim/controllerTrace.txt ====
# name instr ieu {StallD FlushD StallE FlushE StallM FlushM StallW FlushW} flags{eq lt}
# then expected decodeOut execOut memOut wbOut hazardOut, all hex
nop        00000013 0 00000000 00 00000 000000000 00000 000 00
addiX1     00500093 0 00000000 00 00028 804002000 00000 000 00
addRaw     00108133 0 00000000 00 00108 8040020A1 40020 000 00
subFwdMem  401101B3 0 00000000 00 00208 800002022 40021 200 50
lwFwdWb    0001A203 0 00000000 00 00304 800042023 40022 201 48
loadUse    000202B3 0 00000000 00 00400 984102004 40023 202 45
storeWord  0050A023 0 00000000 00 1012A 800002005 4C124 203 40
storeLoad  0040A303 0 00000000 00 00124 0441020A0 40025 244 13
mulLoadUse 021303B3 0 00000000 00 00608 984102086 02120 205 05
mduUse     00038433 0 00000000 00 00700 B00022027 4C126 000 41
csrrsZero  300024F3 0 00000000 00 00001 800002008 58027 246 40
csrrwUse   30049573 0 00000000 00 00901 A01102009 40028 2C7 01
beqDecode  00000463 0 00000000 00 22000 A0188200A 51129 208 40
beqTaken   0020E463 0 00000000 10 22110 01C003808 518AA 289 00
bltuNot    010000EF 0 00000000 10 34080 01C302048 00028 28A 00
jalTaken   04108133 0 00000000 00 08108 82E002A01 00328 008 00
ieuSquash  00108133 1 00000000 00 00108 000002022 40021 008 50
fwdWb      00100593 0 00000000 00 00008 000002022 00022 201 28
stallE     00000013 0 00100100 00 00000 80400202B 00022 002 00
flushE     00000013 0 00010000 00 00000 80400202B 00000 002 00
afterFlush 00000013 0 00000000 00 00000 000000000 4002B 000 00
drain      00000013 0 00000000 00 00000 804002000 00000 20B 00

// ==== sim/tbController.sv ====
module tbController;

  localparam int clkPeriod    = 40;
  localparam int resetCycles  = 10;
  localparam int resetTimeout = 40;              // Negedges allowed for reset release
  localparam int maxLines     = 200;             // Bound on trace lines read
  localparam int runTimeout   = clkPeriod * 400; // Watchdog for the whole run

  logic                       clk;
  logic                       arstN;
  logic [ctrlPkg::instrW-1:0] InstrD;
  logic                       IllegalIeuInstrD;
  logic                       StallD, FlushD, StallE, FlushE;
  logic                       StallM, FlushM, StallW, FlushW;
  logic [1:0]                 FlagsE;            // {equal, less-than}
  ctrlPkg::decodeOutT         decodeOut;
  logic                       InstrValidD;
  ctrlPkg::execOutT           execOut;
  ctrlPkg::memCtrlT           memOut;
  ctrlPkg::wbCtrlT            wbOut;
  ctrlPkg::hazardOutT         hazardOut;
  logic                       CsrWriteFenceM;

  int    errors;
  int    checks;
  string testName;

  controller controller_inst (
    .clk, .arstN, .InstrD, .IllegalIeuInstrD,
    .StallD, .FlushD, .StallE, .FlushE, .StallM, .FlushM, .StallW, .FlushW,
    .FlagsE, .decodeOut, .InstrValidD, .execOut, .memOut, .wbOut,
    .hazardOut, .CsrWriteFenceM
  );

  //////////////////////////////
  // Clock and reset
  always #(clkPeriod / 2) clk = ~clk;

  initial begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #2 arstN = 1'b1;                             // Release just after the 10th edge
  end

  initial begin
    #(runTimeout);
    $display("timeout: the trace did not finish in time");
    $display("Test failed");
    $finish;
  end

  //////////////////////////////
  // Compare tasks, one per result kind
  task automatic checkDecode(input ctrlPkg::decodeOutT exp, input ctrlPkg::decodeOutT act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s decodeOut expected %h actual %h", testName, exp, act);
    end
  endtask

  task automatic checkExec(input ctrlPkg::execOutT exp, input ctrlPkg::execOutT act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s execOut expected %h actual %h", testName, exp, act);
    end
  endtask

  task automatic checkMem(input ctrlPkg::memCtrlT exp, input ctrlPkg::memCtrlT act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s memOut expected %h actual %h", testName, exp, act);
    end
  endtask

  task automatic checkWb(input ctrlPkg::wbCtrlT exp, input ctrlPkg::wbCtrlT act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s wbOut expected %h actual %h", testName, exp, act);
    end
  endtask

  task automatic checkHazard(input ctrlPkg::hazardOutT exp, input ctrlPkg::hazardOutT act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s hazardOut expected %h actual %h", testName, exp, act);
    end
  endtask

  task automatic checkFence(input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s CsrWriteFenceM expected %b actual %b", testName, exp, act);
    end
  endtask

  task automatic checkValid(input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s InstrValidD expected %b actual %b", testName, exp, act);
    end
  endtask

  //////////////////////////////
  // Trace driven stimulus
  initial begin
    int                                   fd;
    int                                   guard;
    int                                   lines;
    int                                   got;
    string                                line;
    logic [ctrlPkg::instrW-1:0]           instrV;
    logic                                 ieuV;
    logic [7:0]                           sfV;   // StallD FlushD StallE FlushE StallM ..
    logic [1:0]                           flagsV;
    logic [$bits(ctrlPkg::decodeOutT)-1:0] decV;
    logic [$bits(ctrlPkg::execOutT)-1:0]   execV;
    logic [$bits(ctrlPkg::memCtrlT)-1:0]   memV;
    logic [$bits(ctrlPkg::wbCtrlT)-1:0]    wbV;
    logic [$bits(ctrlPkg::hazardOutT)-1:0] hazV;
    ctrlPkg::memCtrlT                     memExp;
    logic                                 validExp;  // Decode-valid flop, cleared by reset
    clk              = 1'b0;
    InstrD           = '0;
    IllegalIeuInstrD = 1'b0;
    {StallD, FlushD, StallE, FlushE, StallM, FlushM, StallW, FlushW} = '0;
    FlagsE           = 2'b00;
    errors           = 0;
    checks           = 0;
    testName         = "reset";
    lines            = 0;
    validExp         = 1'b0;
    fd = $fopen("sim/controllerTrace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the trace file sim/controllerTrace.txt");
    end
    guard = 0;
    while (arstN !== 1'b1 && guard < resetTimeout) begin // Reset release
      @(negedge clk);
      guard++;
    end
    if (arstN !== 1'b1) begin
      errors++;
      $display("reset was never released");
    end
    while (fd != 0 && arstN && !$feof(fd) && lines < maxLines) begin
      got = $fgets(line, fd);
      if (got > 0 && line.len() > 1 && line[0] != "#") begin
        got = $sscanf(line, "%s %h %b %b %b %h %h %h %h %h", testName, instrV, ieuV,
                      sfV, flagsV, decV, execV, memV, wbV, hazV);
        if (got != 10) begin
          errors++;
          $display("trace line %0d could not be parsed", lines + 1);
        end else begin
          @(posedge clk);
          if (FlushD)                            // Flush clears, stall holds
            validExp = 1'b0;
          else if (!StallD)
            validExp = 1'b1;
          #2;                                    // Drive after the edge
          InstrD           = instrV;
          IllegalIeuInstrD = ieuV;
          {StallD, FlushD, StallE, FlushE, StallM, FlushM, StallW, FlushW} = sfV;
          FlagsE           = flagsV;
          memExp           = ctrlPkg::memCtrlT'(memV);
          #(clkPeriod - 3);                      // Sample just before the next edge
          checkDecode(ctrlPkg::decodeOutT'(decV), decodeOut);
          checkExec(ctrlPkg::execOutT'(execV), execOut);
          checkMem(memExp, memOut);
          checkWb(ctrlPkg::wbCtrlT'(wbV), wbOut);
          checkHazard(ctrlPkg::hazardOutT'(hazV), hazardOut);
          checkFence(memExp.csrWrite, CsrWriteFenceM);
          checkValid(validExp, InstrValidD);
        end
      end
      lines++;
    end
    if (fd != 0)
      $fclose(fd);
    if (checks == 0) begin
      errors++;
      $display("no trace line was checked");
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
logic/ctrlPkg.sv
logic/instrDecode.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/hazardUnit.sv
logic/controller.sv
sim/tbController.sv
